// File: rtl/cfg_pkg.sv
// ====================================================================
// Shared sizes, configuration address map, modes and command formats
// for the boot configuration subsystem
// ====================================================================
package cfg_pkg;

  // Default sizes, overridden through module parameters at the top
  localparam int num_cores_gp     = 4;
  localparam int ucode_els_gp     = 16;
  localparam int inst_width_gp    = 32;
  localparam int max_credits_gp   = 4;
  localparam int dword_width_gp   = 64;
  localparam int cfg_addr_width_gp = 16;
  localparam int core_id_width_gp = $clog2(num_cores_gp);

  // ====================================================================
  // Address map
  // ====================================================================
  localparam logic [cfg_addr_width_gp-1:0] cfg_reg_reset_gp       = 16'h0001;
  localparam logic [cfg_addr_width_gp-1:0] cfg_reg_freeze_gp      = 16'h0002;
  localparam logic [cfg_addr_width_gp-1:0] cfg_reg_icache_mode_gp = 16'h0003;
  localparam logic [cfg_addr_width_gp-1:0] cfg_reg_dcache_mode_gp = 16'h0004;
  localparam logic [cfg_addr_width_gp-1:0] cfg_reg_cce_mode_gp    = 16'h0005;
  localparam logic [cfg_addr_width_gp-1:0] cfg_mem_base_ucode_gp  = 16'h8000; // Word k at base+k

  typedef enum logic {
    e_lce_mode_uncached = 1'b0,
    e_lce_mode_normal   = 1'b1
  } lce_mode_e;

  typedef enum logic {
    e_cce_mode_uncached = 1'b0,
    e_cce_mode_normal   = 1'b1
  } cce_mode_e;

  // Data word seen as a microcode instruction or as a register value
  typedef union packed {
    struct packed {
      logic [dword_width_gp-inst_width_gp-1:0] pad;
      logic [inst_width_gp-1:0]                inst;
    } ucode;
    struct packed {
      logic [dword_width_gp-2:0] pad;
      logic                      flag;  // Flag or mode bit
    } regval;
  } cfg_data_u;

  typedef struct packed {
    logic [core_id_width_gp-1:0]  core_id;
    logic [cfg_addr_width_gp-1:0] addr;
    cfg_data_u                    data;
  } cfg_cmd_s;

endpackage

// File: rtl/cfg_cmd_if.sv
// ====================================================================
// Configuration command channel, valid/ready handshake
// Loader drives valid and cmd, fabric returns ready
// ====================================================================
interface cfg_cmd_if;

  logic             valid;
  logic             ready;
  cfg_pkg::cfg_cmd_s cmd;

  modport loader (
    output valid,
    output cmd,
    input  ready
  );

  modport fabric (
    input  valid,
    input  cmd,
    output ready
  );

endinterface

// File: rtl/cfg_loader.sv
// ====================================================================
// Boot sequencer that walks every core through the configuration
// phases with credit-limited writes and raises done_o once all are acked
// ====================================================================
module cfg_loader #(
  parameter int num_cores_p   = cfg_pkg::num_cores_gp,
  parameter int ucode_els_p   = cfg_pkg::ucode_els_gp,
  parameter int max_credits_p = cfg_pkg::max_credits_gp,
  parameter     ucode_file_p  = "rtl/cce_ucode.mem",
  localparam int ucode_addr_w_lp = $clog2(ucode_els_p),
  localparam int credit_w_lp     = $clog2(max_credits_p + 1)
) (
  input  logic      clk_i,
  input  logic      reset_i,
  cfg_cmd_if.loader cmd,
  input  logic      resp_v_i,
  output logic      done_o
);

  localparam logic [3:0] s_init          = 4'd0;
  localparam logic [3:0] s_reset_set     = 4'd1;
  localparam logic [3:0] s_freeze_set    = 4'd2;
  localparam logic [3:0] s_reset_clr     = 4'd3;
  localparam logic [3:0] s_ucode         = 4'd4;
  localparam logic [3:0] s_icache_normal = 4'd5;
  localparam logic [3:0] s_dcache_normal = 4'd6;
  localparam logic [3:0] s_drain_cce     = 4'd7;
  localparam logic [3:0] s_cce_normal    = 4'd8;
  localparam logic [3:0] s_freeze_clr    = 4'd9;
  localparam logic [3:0] s_drain_done    = 4'd10;
  localparam logic [3:0] s_done          = 4'd11;

  logic [cfg_pkg::inst_width_gp-1:0] ucode_rom [ucode_els_p];

  initial $readmemb(ucode_file_p, ucode_rom);

  logic [3:0]                           state_r, state_n;
  logic [cfg_pkg::core_id_width_gp-1:0] core_cnt_r;
  logic [ucode_addr_w_lp-1:0]           ucode_cnt_r;
  logic [credit_w_lp-1:0]               credit_cnt_r;
  logic                                 send_v, xfer;
  logic                                 core_last, ucode_last, phase_last;
  logic                                 credits_full, credits_empty;
  cfg_pkg::cfg_cmd_s                    cmd_n;

  assign xfer          = cmd.valid & cmd.ready;
  assign credits_full  = (credit_cnt_r == credit_w_lp'(max_credits_p));
  assign credits_empty = (credit_cnt_r == '0);
  assign core_last     = (core_cnt_r == cfg_pkg::core_id_width_gp'(num_cores_p - 1));
  assign ucode_last    = (ucode_cnt_r == ucode_addr_w_lp'(ucode_els_p - 1));
  assign phase_last    = core_last & ((state_r != s_ucode) | ucode_last);

  assign cmd.valid = send_v & ~credits_full;
  assign cmd.cmd   = cmd_n;
  assign done_o    = (state_r == s_done);

  // ====================================================================
  // Phase FSM and command formation
  // ====================================================================
  always_comb begin
    state_n = state_r;
    send_v  = 1'b0;
    cmd_n   = '0;
    cmd_n.core_id = core_cnt_r;
    case (state_r)
      s_init: state_n = s_reset_set;
      s_reset_set: begin
        send_v = 1'b1;
        cmd_n.addr = cfg_pkg::cfg_reg_reset_gp;
        cmd_n.data.regval.flag = 1'b1;
        if (xfer && phase_last) state_n = s_freeze_set;
      end
      s_freeze_set: begin
        send_v = 1'b1;
        cmd_n.addr = cfg_pkg::cfg_reg_freeze_gp;
        cmd_n.data.regval.flag = 1'b1;
        if (xfer && phase_last) state_n = s_reset_clr;
      end
      s_reset_clr: begin
        send_v = 1'b1;
        cmd_n.addr = cfg_pkg::cfg_reg_reset_gp;
        if (xfer && phase_last) state_n = s_ucode;
      end
      s_ucode: begin
        send_v = 1'b1;
        cmd_n.addr = cfg_pkg::cfg_mem_base_ucode_gp
                     + cfg_pkg::cfg_addr_width_gp'(ucode_cnt_r);
        cmd_n.data.ucode.inst = ucode_rom[ucode_cnt_r];
        if (xfer && phase_last) state_n = s_icache_normal;
      end
      s_icache_normal: begin
        send_v = 1'b1;
        cmd_n.addr = cfg_pkg::cfg_reg_icache_mode_gp;
        cmd_n.data.regval.flag = cfg_pkg::e_lce_mode_normal;
        if (xfer && phase_last) state_n = s_dcache_normal;
      end
      s_dcache_normal: begin
        send_v = 1'b1;
        cmd_n.addr = cfg_pkg::cfg_reg_dcache_mode_gp;
        cmd_n.data.regval.flag = cfg_pkg::e_lce_mode_normal;
        if (xfer && phase_last) state_n = s_drain_cce;
      end
      s_drain_cce: if (credits_empty) state_n = s_cce_normal; // Caches settled first
      s_cce_normal: begin
        send_v = 1'b1;
        cmd_n.addr = cfg_pkg::cfg_reg_cce_mode_gp;
        cmd_n.data.regval.flag = cfg_pkg::e_cce_mode_normal;
        if (xfer && phase_last) state_n = s_freeze_clr;
      end
      s_freeze_clr: begin
        send_v = 1'b1;
        cmd_n.addr = cfg_pkg::cfg_reg_freeze_gp;
        if (xfer && phase_last) state_n = s_drain_done;
      end
      s_drain_done: if (credits_empty) state_n = s_done;
      s_done: state_n = s_done;
      default: state_n = s_init;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r     <= s_init;
      core_cnt_r  <= '0;
      ucode_cnt_r <= '0;
    end else begin
      state_r <= state_n;
      if (xfer) begin
        if (state_r == s_ucode) begin
          ucode_cnt_r <= ucode_last ? '0 : ucode_cnt_r + 1'b1;
          if (ucode_last) core_cnt_r <= core_last ? '0 : core_cnt_r + 1'b1;
        end else begin
          core_cnt_r <= core_last ? '0 : core_cnt_r + 1'b1;
        end
      end
    end
  end

  // One credit per write in flight
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_cnt_r <= '0;
    end else if (xfer && !resp_v_i) begin
      credit_cnt_r <= credit_cnt_r + 1'b1;
    end else if (!xfer && resp_v_i) begin
      credit_cnt_r <= credit_cnt_r - 1'b1;
    end
  end

  a_credit_range: assert property (@(posedge clk_i) disable iff (reset_i)
    !(credits_empty && resp_v_i));

  a_cmd_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd.valid && !cmd.ready |=> cmd.valid && $stable(cmd.cmd));

endmodule

// File: rtl/cfg_fabric.sv
// ====================================================================
// Command router, steers each write to the addressed core and merges
// the per-core acknowledgements into one response strobe
// ====================================================================
module cfg_fabric #(
  parameter int num_cores_p = cfg_pkg::num_cores_gp
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  cfg_cmd_if.fabric              up,
  output logic [num_cores_p-1:0] tgt_v_o,
  output cfg_pkg::cfg_cmd_s      tgt_cmd_o,
  input  logic [num_cores_p-1:0] tgt_ready_i,
  input  logic [num_cores_p-1:0] ack_v_i,
  output logic                   resp_v_o
);

  logic [num_cores_p-1:0] sel;

  // One-hot target decode
  always_comb begin
    for (int i = 0; i < num_cores_p; i++) begin
      sel[i] = (up.cmd.core_id == cfg_pkg::core_id_width_gp'(i));
    end
  end

  assign tgt_v_o   = sel & {num_cores_p{up.valid}};
  assign tgt_cmd_o = up.cmd;                  // Broadcast, valid qualifies
  assign up.ready  = |(sel & tgt_ready_i);
  assign resp_v_o  = |ack_v_i;

  // Single transfer per cycle keeps acks from colliding
  a_ack_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(ack_v_i));

endmodule

// File: rtl/core_cfg_regs.sv
// ====================================================================
// Per-core configuration target, holds the control registers and
// forwards microcode writes into the core's microcode RAM
// ====================================================================
module core_cfg_regs #(
  parameter int ucode_els_p = cfg_pkg::ucode_els_gp,
  localparam int ucode_addr_w_lp = $clog2(ucode_els_p)
) (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              cmd_v_i,
  input  cfg_pkg::cfg_cmd_s                 cmd_i,
  output logic                              ready_o,
  output logic                              ack_v_o,
  output logic                              core_reset_o,
  output logic                              core_freeze_o,
  output cfg_pkg::lce_mode_e                icache_mode_o,
  output cfg_pkg::lce_mode_e                dcache_mode_o,
  output cfg_pkg::cce_mode_e                cce_mode_o,
  output logic                              ucode_w_v_o,
  output logic [ucode_addr_w_lp-1:0]        ucode_w_addr_o,
  output logic [cfg_pkg::inst_width_gp-1:0] ucode_w_data_o,
  input  logic                              fetch_busy_i
);

  logic [cfg_pkg::cfg_addr_width_gp-1:0] ucode_off;
  logic                                  is_ucode, xfer, flag;

  // Offset into microcode space, wraps for register addresses
  assign ucode_off = cmd_i.addr - cfg_pkg::cfg_mem_base_ucode_gp;
  assign is_ucode  = (ucode_off < cfg_pkg::cfg_addr_width_gp'(ucode_els_p));
  assign flag      = cmd_i.data.regval.flag;

  assign ready_o = ~(fetch_busy_i & is_ucode); // Fetch owns the RAM port
  assign xfer    = cmd_v_i & ready_o;

  assign ucode_w_v_o    = xfer & is_ucode;
  assign ucode_w_addr_o = ucode_off[ucode_addr_w_lp-1:0];
  assign ucode_w_data_o = cmd_i.data.ucode.inst;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_v_o       <= 1'b0;
      core_reset_o  <= 1'b1;
      core_freeze_o <= 1'b1;
      icache_mode_o <= cfg_pkg::e_lce_mode_uncached;
      dcache_mode_o <= cfg_pkg::e_lce_mode_uncached;
      cce_mode_o    <= cfg_pkg::e_cce_mode_uncached;
    end else begin
      ack_v_o <= xfer;                        // Every write is acked, even unmapped
      if (xfer && !is_ucode) begin
        case (cmd_i.addr)
          cfg_pkg::cfg_reg_reset_gp:       core_reset_o  <= flag;
          cfg_pkg::cfg_reg_freeze_gp:      core_freeze_o <= flag;
          cfg_pkg::cfg_reg_icache_mode_gp: icache_mode_o <= cfg_pkg::lce_mode_e'(flag);
          cfg_pkg::cfg_reg_dcache_mode_gp: dcache_mode_o <= cfg_pkg::lce_mode_e'(flag);
          cfg_pkg::cfg_reg_cce_mode_gp:    cce_mode_o    <= cfg_pkg::cce_mode_e'(flag);
          default: ;
        endcase
      end
    end
  end

endmodule

// File: rtl/cce_ucode_ram.sv
// ====================================================================
// Coherence engine microcode store, single port with registered read
// Fetch reads take priority over configuration writes
// ====================================================================
module cce_ucode_ram #(
  parameter int ucode_els_p = cfg_pkg::ucode_els_gp,
  localparam int ucode_addr_w_lp = $clog2(ucode_els_p)
) (
  input  logic                              clk_i,
  input  logic                              ucode_w_v_i,
  input  logic [ucode_addr_w_lp-1:0]        ucode_w_addr_i,
  input  logic [cfg_pkg::inst_width_gp-1:0] ucode_w_data_i,
  input  logic                              rd_v_i,
  input  logic [ucode_addr_w_lp-1:0]        rd_addr_i,
  output logic [cfg_pkg::inst_width_gp-1:0] rd_data_o
);

  logic [cfg_pkg::inst_width_gp-1:0] mem [ucode_els_p];

  always_ff @(posedge clk_i) begin
    if (rd_v_i) begin
      rd_data_o <= mem[rd_addr_i];            // Data valid next cycle
    end else if (ucode_w_v_i) begin
      mem[ucode_w_addr_i] <= ucode_w_data_i;
    end
  end

  // Register block holds writes off while a fetch is active
  a_no_rw_collision: assert property (@(posedge clk_i)
    !(ucode_w_v_i && rd_v_i));

endmodule

// File: rtl/cfg_subsystem_top.sv
// ====================================================================
// Boot configuration subsystem, loader and fabric feeding one register
// block and microcode RAM per core; fetch ports are exposed per core
// ====================================================================
module cfg_subsystem_top #(
  parameter int num_cores_p   = cfg_pkg::num_cores_gp,
  parameter int ucode_els_p   = cfg_pkg::ucode_els_gp,
  parameter int max_credits_p = cfg_pkg::max_credits_gp,
  localparam int ucode_addr_w_lp = $clog2(ucode_els_p)
) (
  input  logic                                                clk_i,
  input  logic                                                reset_i,
  output logic                                                done_o,
  output logic [num_cores_p-1:0]                              core_reset_o,
  output logic [num_cores_p-1:0]                              core_freeze_o,
  output logic [num_cores_p-1:0]                              icache_mode_o,
  output logic [num_cores_p-1:0]                              dcache_mode_o,
  output logic [num_cores_p-1:0]                              cce_mode_o,
  input  logic [num_cores_p-1:0]                              ucode_rd_v_i,
  input  logic [num_cores_p-1:0][ucode_addr_w_lp-1:0]         ucode_rd_addr_i,
  output logic [num_cores_p-1:0][cfg_pkg::inst_width_gp-1:0]  ucode_rd_data_o
);

  cfg_cmd_if cmd_if ();

  logic [num_cores_p-1:0] tgt_v, tgt_ready, ack_v;
  logic                   resp_v;
  cfg_pkg::cfg_cmd_s      tgt_cmd;

  cfg_loader #(
    .num_cores_p  (num_cores_p),
    .ucode_els_p  (ucode_els_p),
    .max_credits_p(max_credits_p)
  ) i_cfg_loader (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .cmd     (cmd_if.loader),
    .resp_v_i(resp_v),
    .done_o  (done_o)
  );

  cfg_fabric #(
    .num_cores_p(num_cores_p)
  ) i_cfg_fabric (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .up         (cmd_if.fabric),
    .tgt_v_o    (tgt_v),
    .tgt_cmd_o  (tgt_cmd),
    .tgt_ready_i(tgt_ready),
    .ack_v_i    (ack_v),
    .resp_v_o   (resp_v)
  );

  // ====================================================================
  // Per-core configuration target and microcode store
  // ====================================================================
  for (genvar i = 0; i < num_cores_p; i++) begin : g_core
    logic                              ucode_w_v;
    logic [ucode_addr_w_lp-1:0]        ucode_w_addr;
    logic [cfg_pkg::inst_width_gp-1:0] ucode_w_data;

    core_cfg_regs #(
      .ucode_els_p(ucode_els_p)
    ) i_core_cfg_regs (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .cmd_v_i       (tgt_v[i]),
      .cmd_i         (tgt_cmd),
      .ready_o       (tgt_ready[i]),
      .ack_v_o       (ack_v[i]),
      .core_reset_o  (core_reset_o[i]),
      .core_freeze_o (core_freeze_o[i]),
      .icache_mode_o (icache_mode_o[i]),
      .dcache_mode_o (dcache_mode_o[i]),
      .cce_mode_o    (cce_mode_o[i]),
      .ucode_w_v_o   (ucode_w_v),
      .ucode_w_addr_o(ucode_w_addr),
      .ucode_w_data_o(ucode_w_data),
      .fetch_busy_i  (ucode_rd_v_i[i])
    );

    cce_ucode_ram #(
      .ucode_els_p(ucode_els_p)
    ) i_cce_ucode_ram (
      .clk_i         (clk_i),
      .ucode_w_v_i   (ucode_w_v),
      .ucode_w_addr_i(ucode_w_addr),
      .ucode_w_data_i(ucode_w_data),
      .rd_v_i        (ucode_rd_v_i[i]),
      .rd_addr_i     (ucode_rd_addr_i[i]),
      .rd_data_o     (ucode_rd_data_o[i])
    );
  end

endmodule

// File: verification/tb_cfg_subsystem.sv
// ====================================================================
// Self-checking testbench for the boot configuration subsystem
// Boots under random fetch traffic, then checks final state and RAMs
// ====================================================================
module tb_cfg_subsystem;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_cores    = cfg_pkg::num_cores_gp;
  localparam int ucode_els    = cfg_pkg::ucode_els_gp;
  localparam int max_credits  = cfg_pkg::max_credits_gp;
  localparam int addr_w       = $clog2(ucode_els);
  localparam int inst_w       = cfg_pkg::inst_width_gp;
  localparam int total_writes = num_cores * (ucode_els + 7); // 7 register writes per core
  localparam int hold_cycles  = 50;
  // Load budget plus readback, hold phase and margin
  localparam int limit_cycles = 20 * total_writes + 3 * ucode_els + hold_cycles + 200;

  localparam logic lce_normal = cfg_pkg::e_lce_mode_normal;
  localparam logic cce_normal = cfg_pkg::e_cce_mode_normal;

  typedef logic [num_cores-1:0] ctrl_t;
  typedef logic [inst_w-1:0]    word_t;

  logic                             clk_i = 1'b0;
  logic                             reset_i;
  logic                             done;
  ctrl_t                            core_reset, core_freeze;
  ctrl_t                            icache_mode, dcache_mode, cce_mode;
  ctrl_t                            ucode_rd_v;
  logic [num_cores-1:0][addr_w-1:0] ucode_rd_addr;
  logic [num_cores-1:0][inst_w-1:0] ucode_rd_data;

  word_t                            ucode_img [ucode_els];
  integer                           seed;
  ctrl_t                            prev_reset, prev_freeze, prev_cce;
  ctrl_t                            issued_v;
  logic [num_cores-1:0][addr_w-1:0] issued_addr;

  cfg_subsystem_top #(
    .num_cores_p  (num_cores),
    .ucode_els_p  (ucode_els),
    .max_credits_p(max_credits)
  ) i_cfg_subsystem_top (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .done_o         (done),
    .core_reset_o   (core_reset),
    .core_freeze_o  (core_freeze),
    .icache_mode_o  (icache_mode),
    .dcache_mode_o  (dcache_mode),
    .cce_mode_o     (cce_mode),
    .ucode_rd_v_i   (ucode_rd_v),
    .ucode_rd_addr_i(ucode_rd_addr),
    .ucode_rd_data_o(ucode_rd_data)
  );

  always #5 clk_i = ~clk_i;

  // ====================================================================
  // Reference model and compare tasks
  // ====================================================================
  // Every core is loaded from the same boot image
  function automatic word_t ref_word(input int core, input int addr);
    return ucode_img[addr];
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_ctrl(input string name, input ctrl_t got, input ctrl_t exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_final_state();
    check_flag("done_o", done, 1'b1);
    check_ctrl("core_reset_o", core_reset, '0);
    check_ctrl("core_freeze_o", core_freeze, '0);
    check_ctrl("icache_mode_o", icache_mode, {num_cores{lce_normal}});
    check_ctrl("dcache_mode_o", dcache_mode, {num_cores{lce_normal}});
    check_ctrl("cce_mode_o", cce_mode, {num_cores{cce_normal}});
  endtask

  // Each core fetches on about half the cycles
  task automatic drive_fetches();
    ctrl_t                            v;
    logic [num_cores-1:0][addr_w-1:0] a;
    for (int i = 0; i < num_cores; i++) begin
      v[i] = (($random(seed) & 1) == 1);
      a[i] = addr_w'($random(seed));
    end
    ucode_rd_v    <= v;
    ucode_rd_addr <= a;
  endtask

  // ====================================================================
  // Phase order monitor
  // ====================================================================
  always @(negedge clk_i) begin
    if (!reset_i) begin
      for (int i = 0; i < num_cores; i++) begin
        if (prev_reset[i] && !core_reset[i] && !core_freeze[i]) begin
          abort_run($sformatf("core %0d left reset while not frozen", i));
        end
        if (!prev_cce[i] && cce_mode[i] && !(icache_mode[i] && dcache_mode[i])) begin
          abort_run($sformatf("core %0d coherence engine normal before both caches", i));
        end
        if (prev_freeze[i] && !core_freeze[i] && !cce_mode[i]) begin
          abort_run($sformatf("core %0d unfrozen before coherence engine normal", i));
        end
      end
    end
    prev_reset  = core_reset;
    prev_freeze = core_freeze;
    prev_cce    = cce_mode;
  end

  initial begin
    repeat (limit_cycles) @(posedge clk_i);
    abort_run($sformatf("timeout, run did not complete within %0d cycles", limit_cycles));
  end

  // ====================================================================
  // Stimulus
  // ====================================================================
  initial begin
    seed          = 32'h680831d8;
    reset_i       = 1'b1;
    ucode_rd_v    = '0;
    ucode_rd_addr = '0;
    issued_v      = '0;
    issued_addr   = '0;
    $readmemb("rtl/cce_ucode.mem", ucode_img);
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;

    @(negedge clk_i);
    check_flag("done_o", done, 1'b0);
    check_ctrl("core_reset_o", core_reset, '1);
    check_ctrl("core_freeze_o", core_freeze, '1);
    check_ctrl("icache_mode_o", icache_mode, '0);
    check_ctrl("dcache_mode_o", dcache_mode, '0);
    check_ctrl("cce_mode_o", cce_mode, '0);

    while (done !== 1'b1) begin                // Fetches stall microcode writes
      @(posedge clk_i);
      drive_fetches();
      @(negedge clk_i);
    end
    check_final_state();

    // Read back every word of every core
    for (int a = 0; a < ucode_els; a++) begin
      @(posedge clk_i);
      ucode_rd_v <= '1;
      for (int c = 0; c < num_cores; c++) begin
        ucode_rd_addr[c] <= addr_w'(a);
      end
      @(posedge clk_i);
      ucode_rd_v <= '0;
      @(negedge clk_i);
      for (int c = 0; c < num_cores; c++) begin
        check_word($sformatf("ucode_rd_data_o[%0d] addr %0d", c, a),
                   ucode_rd_data[c], ref_word(c, a));
      end
    end

    // Outputs hold while fetch traffic continues
    for (int n = 0; n < hold_cycles; n++) begin
      @(posedge clk_i);
      issued_v    = ucode_rd_v;                // Sampled by the DUT on this edge
      issued_addr = ucode_rd_addr;
      drive_fetches();
      @(negedge clk_i);
      check_final_state();
      for (int c = 0; c < num_cores; c++) begin
        if (issued_v[c]) begin
          check_word($sformatf("ucode_rd_data_o[%0d] addr %0d", c, issued_addr[c]),
                     ucode_rd_data[c], ref_word(c, int'(issued_addr[c])));
        end
      end
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

// File: rtl/cce_ucode.mem
// Boot microcode image: one 32-bit instruction per line in binary, word 0 first
0001_0000_0000_0000_0000_0000_0000_0001
0010_1010_0101_1111_0000_0000_0001_0010
0011_1100_0000_1111_0000_0000_1010_0011
0100_1000_0000_0001_1111_1111_0000_0100
0101_1110_0111_0111_1010_0000_0110_0101
0110_0001_0010_0011_1000_1000_0000_0110
0111_1111_0000_0000_1100_0100_1110_0111
1000_1011_1010_1101_1111_0000_0000_1000
1001_0000_1111_0001_1110_0010_1101_1001
1010_0011_1100_0011_1100_0011_0000_1010
1011_0000_0000_1011_0000_1011_0001_1011
1100_0110_1101_0111_1110_1000_1111_1100
1101_0001_0000_0010_0000_0011_0000_0100
1110_0101_1010_0101_1010_0101_0101_1101
1111_0000_1111_0000_1111_0000_1111_1110
0000_1111_1110_1101_1100_1011_1010_1111

// File: vlog.f
rtl/cfg_pkg.sv
rtl/cfg_cmd_if.sv
rtl/cfg_loader.sv
rtl/cfg_fabric.sv
rtl/core_cfg_regs.sv
rtl/cce_ucode_ram.sv
rtl/cfg_subsystem_top.sv
verification/tb_cfg_subsystem.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the boot configuration testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_cfg_subsystem -Mdir "$build_dir" -f vlog.f
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

"./$build_dir/Vtb_cfg_subsystem" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q "TB FAILED" "$log_file"; then
  echo "Simulation reported failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
echo "Simulation passed"
exit 0
